// File: hdl/adc_capture.sv
// DDR halves must already be aligned to adc_clk_01; fixed 2-cycle latency, no back-pressure
`timescale 1ns/1ns
`default_nettype none

module adc_capture (
  input  wire                                        adc_clk_01,
  input  wire                                        rst_i,
  input  wire  rp_pkg::adc_half_t   [rp_pkg::ADC_CH-1:0] adc_rise_i,  // rising edge halves
  input  wire  rp_pkg::adc_half_t   [rp_pkg::ADC_CH-1:0] adc_fall_i,  // falling edge halves
  output rp_pkg::adc_sample_t       [rp_pkg::ADC_CH-1:0] adc_dat_o
);

  import rp_pkg::*;

  wire logic  [ADC_CH-1:0][ADC_DW-1:0] adc_raw;  // interleaved ADC code
  adc_sample_t [ADC_CH-1:0]            conv_r;   // first stage, converted

  ////////////////////////////////////////////////////////////
  // per channel bit interleave
  ////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < ADC_CH; ch++) begin : g_ch
    for (genvar k = 0; k < ADC_HALF_W; k++) begin : g_bit
      assign adc_raw[ch][2*k]   = adc_fall_i[ch][k];  // even bits on falling edge
      assign adc_raw[ch][2*k+1] = adc_rise_i[ch][k];  // odd bits on rising edge
    end
  end

  ////////////////////////////////////////////////////////////
  // code conversion and output stage
  ////////////////////////////////////////////////////////////

  // ADC delivers offset code with negative slope;
  // keeping the MSB and inverting the rest gives two's complement
  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      conv_r    <= '0;
      adc_dat_o <= '0;
    end else begin
      for (int ch = 0; ch < ADC_CH; ch++) begin
        conv_r[ch] <= {adc_raw[ch][ADC_DW-1], ~adc_raw[ch][ADC_DW-2:0]};
      end
      adc_dat_o <= conv_r;  // second register, eases routing to consumers
    end
  end

endmodule

`default_nettype wire

// File: hdl/housekeeping_regs.sv
// expansion port inputs are read as driven, no synchronizer; unknown offsets read zero
`timescale 1ns/1ns
`default_nettype none

module housekeeping_regs (
  input  wire                           adc_clk_01,
  input  wire                           rst_i,
  // register bus, region 0
  input  wire  [rp_pkg::REGION_LSB-1:0] addr_i,
  input  wire  rp_pkg::sys_data_t       wdata_i,
  input  wire                           wen_i,
  input  wire                           ren_i,
  output rp_pkg::sys_data_t             rdata_o,
  output logic                          ack_o,
  // LEDs and expansion connector
  output logic [rp_pkg::LED_W-1:0]      led_o,
  input  wire  [rp_pkg::EXP_W-1:0]      exp_p_dat_i,
  input  wire  [rp_pkg::EXP_W-1:0]      exp_n_dat_i,
  output logic [rp_pkg::EXP_W-1:0]      exp_p_dat_o,
  output logic [rp_pkg::EXP_W-1:0]      exp_n_dat_o,
  output logic [rp_pkg::EXP_W-1:0]      exp_p_dir_o,  // 1 = pin driven
  output logic [rp_pkg::EXP_W-1:0]      exp_n_dir_o
);

  import rp_pkg::*;

  // write side, outputs come straight from the registers
  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      ack_o       <= 1'b0;
      led_o       <= '0;
      exp_p_dat_o <= '0;
      exp_n_dat_o <= '0;
      exp_p_dir_o <= '0;  // all pins inputs
      exp_n_dir_o <= '0;
    end else begin
      ack_o <= wen_i | ren_i;  // every access answered next cycle
      if (wen_i) begin
        case (hk_reg_e'(addr_i))
          HK_EXP_P_DIR: exp_p_dir_o <= wdata_i[EXP_W-1:0];
          HK_EXP_N_DIR: exp_n_dir_o <= wdata_i[EXP_W-1:0];
          HK_EXP_P_OUT: exp_p_dat_o <= wdata_i[EXP_W-1:0];
          HK_EXP_N_OUT: exp_n_dat_o <= wdata_i[EXP_W-1:0];
          HK_LED:       led_o       <= wdata_i[LED_W-1:0];
          default: ;  // ID, inputs and holes ignore writes
        endcase
      end
    end
  end

  // read side
  always_ff @(posedge adc_clk_01) begin
    if (ren_i) begin
      case (hk_reg_e'(addr_i))
        HK_ID:        rdata_o <= HK_ID_VALUE;
        HK_EXP_P_DIR: rdata_o <= sys_data_t'(exp_p_dir_o);
        HK_EXP_N_DIR: rdata_o <= sys_data_t'(exp_n_dir_o);
        HK_EXP_P_OUT: rdata_o <= sys_data_t'(exp_p_dat_o);
        HK_EXP_N_OUT: rdata_o <= sys_data_t'(exp_n_dat_o);
        HK_EXP_P_IN:  rdata_o <= sys_data_t'(exp_p_dat_i);  // pin state
        HK_EXP_N_IN:  rdata_o <= sys_data_t'(exp_n_dat_i);
        HK_LED:       rdata_o <= sys_data_t'(led_o);
        default:      rdata_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/pdm_modulator.sv
// first-order PDM, period 256 cycles; an external RC filter is expected on each output
`timescale 1ns/1ns
`default_nettype none

module pdm_modulator (
  input  wire                                    adc_clk_01,
  input  wire                                    rst_i,
  input  wire  rp_pkg::pdm_cfg_t [rp_pkg::ADC_CH-1:0] pdm_cfg_i,
  output logic [rp_pkg::ADC_CH-1:0]              dac_pwm_o
);

  import rp_pkg::*;

  logic [ADC_CH-1:0][$bits(pdm_cfg_t)-1:0] acc;  // per channel accumulator

  // setting c adds c/256 per cycle, each wrap is one pulse
  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      acc       <= '0;
      dac_pwm_o <= '0;
    end else begin
      for (int ch = 0; ch < ADC_CH; ch++) begin
        {dac_pwm_o[ch], acc[ch]} <= {1'b0, acc[ch]} + {1'b0, pdm_cfg_i[ch]};  // carry out
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < ADC_CH; ch++) begin : g_chk
    // zero setting must not leak pulses from the accumulator state
    a_zero_stays_low: assert property (
      @(posedge adc_clk_01) disable iff (rst_i)
      (pdm_cfg_i[ch] == '0) && $past(pdm_cfg_i[ch] == '0) |-> !dac_pwm_o[ch]
    );
  end

endmodule

`default_nettype wire

// File: hdl/pdm_regs.sv
// four 8-bit settings at byte stride 4 in region 4; other offsets read zero and ignore writes
`timescale 1ns/1ns
`default_nettype none

module pdm_regs (
  input  wire                                     adc_clk_01,
  input  wire                                     rst_i,
  // register bus, region 4
  input  wire  [rp_pkg::REGION_LSB-1:0]           addr_i,
  input  wire  rp_pkg::sys_data_t                 wdata_i,
  input  wire                                     wen_i,
  input  wire                                     ren_i,
  output rp_pkg::sys_data_t                       rdata_o,
  output logic                                    ack_o,
  // settings to the modulators
  output rp_pkg::pdm_cfg_t [rp_pkg::ADC_CH-1:0]   pdm_cfg_o
);

  import rp_pkg::*;

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      ack_o     <= 1'b0;
      pdm_cfg_o <= '0;  // outputs idle low
    end else begin
      ack_o <= wen_i | ren_i;
      if (wen_i) begin
        for (int ch = 0; ch < ADC_CH; ch++) begin
          if (addr_i == REGION_LSB'(ch * PDM_REG_STRIDE)) begin
            pdm_cfg_o[ch] <= wdata_i[$bits(pdm_cfg_t)-1:0];  // upper bits dropped
          end
        end
      end
    end
  end

  // readback, zero extended
  always_ff @(posedge adc_clk_01) begin
    if (ren_i) begin
      rdata_o <= '0;
      for (int ch = 0; ch < ADC_CH; ch++) begin
        if (addr_i == REGION_LSB'(ch * PDM_REG_STRIDE)) begin
          rdata_o <= sys_data_t'(pdm_cfg_o[ch]);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/rp_analog_top.sv
// analog data path only, single clock adc_clk_01; expansion pins leave as separate dat/dir
`timescale 1ns/1ns
`default_nettype none

module rp_analog_top (
  input  wire                                        adc_clk_01,
  input  wire                                        rst_i,
  // ADC
  input  wire  rp_pkg::adc_half_t   [rp_pkg::ADC_CH-1:0] adc_rise_i,
  input  wire  rp_pkg::adc_half_t   [rp_pkg::ADC_CH-1:0] adc_fall_i,
  output rp_pkg::adc_sample_t       [rp_pkg::ADC_CH-1:0] adc_dat_o,
  // register bus
  input  wire  rp_pkg::sys_addr_t                    sys_addr_i,
  input  wire  rp_pkg::sys_data_t                    sys_wdata_i,
  input  wire                                        sys_wen_i,
  input  wire                                        sys_ren_i,
  output rp_pkg::sys_data_t                          sys_rdata_o,
  output logic                                       sys_ack_o,
  output logic                                       sys_err_o,
  // LEDs and expansion connector
  output logic [rp_pkg::LED_W-1:0]                   led_o,
  input  wire  [rp_pkg::EXP_W-1:0]                   exp_p_dat_i,
  input  wire  [rp_pkg::EXP_W-1:0]                   exp_n_dat_i,
  output logic [rp_pkg::EXP_W-1:0]                   exp_p_dat_o,
  output logic [rp_pkg::EXP_W-1:0]                   exp_n_dat_o,
  output logic [rp_pkg::EXP_W-1:0]                   exp_p_dir_o,
  output logic [rp_pkg::EXP_W-1:0]                   exp_n_dir_o,
  // PDM DAC
  output logic [rp_pkg::ADC_CH-1:0]                  dac_pwm_o
);

  import rp_pkg::*;

  logic [REGION_LSB-1:0]    loc_addr;  // offset inside region
  logic                     hk_wen, hk_ren, hk_ack;
  sys_data_t                hk_rdata;
  logic                     pdm_wen, pdm_ren, pdm_ack;
  sys_data_t                pdm_rdata;
  pdm_cfg_t [ADC_CH-1:0]    pdm_cfg;

  ////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////

  adc_capture adc_capture0 (
    .adc_clk_01 (adc_clk_01),
    .rst_i      (rst_i),
    .adc_rise_i (adc_rise_i),
    .adc_fall_i (adc_fall_i),
    .adc_dat_o  (adc_dat_o)
  );

  ////////////////////////////////////////////////////////////
  // register bus and settings
  ////////////////////////////////////////////////////////////

  sys_bus_decoder sys_bus_decoder0 (
    .adc_clk_01  (adc_clk_01),
    .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .loc_addr_o  (loc_addr),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .pdm_wen_o   (pdm_wen),
    .pdm_ren_o   (pdm_ren),
    .pdm_rdata_i (pdm_rdata),
    .pdm_ack_i   (pdm_ack)
  );

  housekeeping_regs housekeeping_regs0 (
    .adc_clk_01  (adc_clk_01),
    .rst_i       (rst_i),
    .addr_i      (loc_addr),
    .wdata_i     (sys_wdata_i),  // write data shared by all regions
    .wen_i       (hk_wen),
    .ren_i       (hk_ren),
    .rdata_o     (hk_rdata),
    .ack_o       (hk_ack),
    .led_o       (led_o),
    .exp_p_dat_i (exp_p_dat_i),
    .exp_n_dat_i (exp_n_dat_i),
    .exp_p_dat_o (exp_p_dat_o),
    .exp_n_dat_o (exp_n_dat_o),
    .exp_p_dir_o (exp_p_dir_o),
    .exp_n_dir_o (exp_n_dir_o)
  );

  pdm_regs pdm_regs0 (
    .adc_clk_01 (adc_clk_01),
    .rst_i      (rst_i),
    .addr_i     (loc_addr),
    .wdata_i    (sys_wdata_i),
    .wen_i      (pdm_wen),
    .ren_i      (pdm_ren),
    .rdata_o    (pdm_rdata),
    .ack_o      (pdm_ack),
    .pdm_cfg_o  (pdm_cfg)
  );

  ////////////////////////////////////////////////////////////
  // output side
  ////////////////////////////////////////////////////////////

  pdm_modulator pdm_modulator0 (
    .adc_clk_01 (adc_clk_01),
    .rst_i      (rst_i),
    .pdm_cfg_i  (pdm_cfg),
    .dac_pwm_o  (dac_pwm_o)
  );

endmodule

`default_nettype wire

// File: hdl/rp_pkg.sv
// shared widths and encodings; one sample clock assumed, bus offsets are byte addresses
`default_nettype none

package rp_pkg;

  ////////////////////////////////////////////////////////////
  // ADC samples
  ////////////////////////////////////////////////////////////

  localparam int ADC_CH     = 4;   // acquisition channels
  localparam int ADC_DW     = 14;  // full sample width
  localparam int ADC_HALF_W = 7;   // bits per DDR half-word

  typedef logic [ADC_HALF_W-1:0]    adc_half_t;    // one edge of the DDR pair
  typedef logic signed [ADC_DW-1:0] adc_sample_t;  // two's complement

  ////////////////////////////////////////////////////////////
  // register bus
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] sys_addr_t;
  typedef logic [31:0] sys_data_t;

  localparam int REGION_LSB = 20;  // region offset is the low 20 bits
  localparam int REGION_W   = 3;   // eight regions

  // only mapped regions are named, the rest answer with err
  typedef enum logic [REGION_W-1:0] {
    REGION_HK  = 3'd0,  // housekeeping
    REGION_PDM = 3'd4   // analog output settings
  } region_e;

  // housekeeping byte offsets
  typedef enum logic [REGION_LSB-1:0] {
    HK_ID        = 20'h00,
    HK_EXP_P_DIR = 20'h10,
    HK_EXP_N_DIR = 20'h14,
    HK_EXP_P_OUT = 20'h18,
    HK_EXP_N_OUT = 20'h1C,
    HK_EXP_P_IN  = 20'h20,
    HK_EXP_N_IN  = 20'h24,
    HK_LED       = 20'h30
  } hk_reg_e;

  localparam sys_data_t HK_ID_VALUE = 32'h5250_0414;  // board id, 4 ch / 14 bit

  localparam int EXP_W = 8;  // expansion connector port width
  localparam int LED_W = 8;

  ////////////////////////////////////////////////////////////
  // analog outputs
  ////////////////////////////////////////////////////////////

  typedef logic [7:0] pdm_cfg_t;  // pulse density, 0..255 of 256

  localparam int PDM_REG_STRIDE = 4;  // channel n at offset 4*n

endpackage

`default_nettype wire

// File: hdl/sys_bus_decoder.sv
// one strobe per access and one response per strobe; unmapped regions answer ack with err
`timescale 1ns/1ns
`default_nettype none

module sys_bus_decoder (
  input  wire                           adc_clk_01,
  input  wire                           rst_i,
  // bus master side
  input  wire  rp_pkg::sys_addr_t       sys_addr_i,
  input  wire                           sys_wen_i,
  input  wire                           sys_ren_i,
  output rp_pkg::sys_data_t             sys_rdata_o,
  output logic                          sys_ack_o,
  output logic                          sys_err_o,
  // region offset, shared by all responders
  output logic [rp_pkg::REGION_LSB-1:0] loc_addr_o,
  // region 0, housekeeping
  output logic                          hk_wen_o,
  output logic                          hk_ren_o,
  input  wire  rp_pkg::sys_data_t       hk_rdata_i,
  input  wire                           hk_ack_i,
  // region 4, analog outputs
  output logic                          pdm_wen_o,
  output logic                          pdm_ren_o,
  input  wire  rp_pkg::sys_data_t       pdm_rdata_i,
  input  wire                           pdm_ack_i
);

  import rp_pkg::*;

  region_e region;      // region of the current strobe
  region_e rsp_region;  // region of the access being answered
  logic    strobe;
  logic    mapped;
  logic    err_r;       // error response for unmapped regions

  assign region     = region_e'(sys_addr_i[REGION_LSB +: REGION_W]);
  assign loc_addr_o = sys_addr_i[REGION_LSB-1:0];
  assign strobe     = sys_wen_i | sys_ren_i;
  assign mapped     = (region == REGION_HK) || (region == REGION_PDM);

  // strobe routing
  assign hk_wen_o  = sys_wen_i & (region == REGION_HK);
  assign hk_ren_o  = sys_ren_i & (region == REGION_HK);
  assign pdm_wen_o = sys_wen_i & (region == REGION_PDM);
  assign pdm_ren_o = sys_ren_i & (region == REGION_PDM);

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      rsp_region <= REGION_HK;
      err_r      <= 1'b0;
    end else begin
      err_r <= strobe & ~mapped;  // stub answer, 1 cycle like the responders
      if (strobe) begin
        rsp_region <= region;  // a new strobe may overlap the previous ack
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // response mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (rsp_region)
      REGION_HK: begin
        sys_ack_o   = hk_ack_i;
        sys_rdata_o = hk_rdata_i;
      end
      REGION_PDM: begin
        sys_ack_o   = pdm_ack_i;
        sys_rdata_o = pdm_rdata_i;
      end
      default: begin
        sys_ack_o   = err_r;
        sys_rdata_o = '0;  // nothing to read in a stub region
      end
    endcase
  end

  assign sys_err_o = err_r;

  // error only ever comes as part of a response
  a_err_has_ack: assert property (
    @(posedge adc_clk_01) disable iff (rst_i)
    sys_err_o |-> sys_ack_o
  );

  // responders and stub never answer unasked
  a_ack_after_strobe: assert property (
    @(posedge adc_clk_01) disable iff (rst_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i)
  );

endmodule

`default_nettype wire

// File: testbench/tb_checks.svh
// included in the body of tb_rp_analog_top; relies on its bus signals, counters and DRV_DLY
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////////////
// compare tasks, one per result type
////////////////////////////////////////////////////////////

task automatic check_sample(input string what, input adc_sample_t got, input adc_sample_t exp);
  check_total++;
  if (got !== exp) begin
    err_total++;
    $display("[ERROR] %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
  end
endtask

task automatic check_data(input string what, input sys_data_t got, input sys_data_t exp);
  check_total++;
  if (got !== exp) begin
    err_total++;
    $display("[ERROR] %0t ns: %s got %08h, expected %08h", $time, what, got, exp);
  end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
  check_total++;
  if (got !== exp) begin
    err_total++;
    $display("[ERROR] %0t ns: %s got %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic check_count(input string what, input int got, input int exp);
  check_total++;
  if (got != exp) begin
    err_total++;
    $display("[ERROR] %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
  end
endtask

////////////////////////////////////////////////////////////
// bus access, called and left at the drive point
////////////////////////////////////////////////////////////

task automatic bus_write(input sys_addr_t addr, input sys_data_t data,
                         output logic ack, output logic err);
  sys_addr  = addr;
  sys_wdata = data;
  sys_wen   = 1'b1;
  @(posedge adc_clk_01);  // strobe taken here
  #DRV_DLY;
  sys_wen = 1'b0;
  ack     = sys_ack;  // response belongs to this cycle
  err     = sys_err;
endtask

task automatic bus_read(input sys_addr_t addr, output sys_data_t data,
                        output logic ack, output logic err);
  sys_addr = addr;
  sys_ren  = 1'b1;
  @(posedge adc_clk_01);
  #DRV_DLY;
  sys_ren = 1'b0;
  data    = sys_rdata;  // valid with ack
  ack     = sys_ack;
  err     = sys_err;
endtask

// accesses expected to succeed
task automatic write_ok(input string what, input sys_addr_t addr, input sys_data_t data);
  logic ack;
  logic err;
  bus_write(addr, data, ack, err);
  check_bit({what, " ack"}, ack, 1'b1);
  check_bit({what, " err"}, err, 1'b0);
endtask

task automatic read_ok(input string what, input sys_addr_t addr, output sys_data_t data);
  logic ack;
  logic err;
  bus_read(addr, data, ack, err);
  check_bit({what, " ack"}, ack, 1'b1);
  check_bit({what, " err"}, err, 1'b0);
endtask

// one cycle with no strobe, response must be gone
task automatic idle_cycle();
  @(posedge adc_clk_01);
  #DRV_DLY;
  check_bit("ack after idle cycle", sys_ack, 1'b0);
  check_bit("err after idle cycle", sys_err, 1'b0);
endtask

`endif

// File: testbench/tb_rp_analog_top.sv
// directed tests of rp_analog_top; one bus access in flight, inputs driven 2 ns after each edge
`timescale 1ns/1ns
`default_nettype none

module tb_rp_analog_top;

  import rp_pkg::*;

  localparam int CLK_HALF = 20;  // 40 ns period
  localparam int DRV_DLY  = 2;   // drive after the rising edge
  // cycle budgets per test
  localparam int T_RESET    = 400;
  localparam int T_ADC      = 150;
  localparam int T_HK       = 200;
  localparam int T_UNMAPPED = 150;
  localparam int T_PDM      = 600;
  localparam int TIMEOUT_CYCLES = 2 * (T_RESET + T_ADC + T_HK + T_UNMAPPED + T_PDM);

  logic                    adc_clk_01;
  logic                    rst_i;
  adc_half_t [ADC_CH-1:0]  adc_rise;
  adc_half_t [ADC_CH-1:0]  adc_fall;
  adc_sample_t [ADC_CH-1:0] adc_dat;
  sys_addr_t               sys_addr;
  sys_data_t               sys_wdata;
  logic                    sys_wen;
  logic                    sys_ren;
  sys_data_t               sys_rdata;
  logic                    sys_ack;
  logic                    sys_err;
  logic [LED_W-1:0]        led;
  logic [EXP_W-1:0]        exp_p_in;   // driven connector pins
  logic [EXP_W-1:0]        exp_n_in;
  logic [EXP_W-1:0]        exp_p_dat;
  logic [EXP_W-1:0]        exp_n_dat;
  logic [EXP_W-1:0]        exp_p_dir;
  logic [EXP_W-1:0]        exp_n_dir;
  logic [ADC_CH-1:0]       dac_pwm;

  int          check_total;
  int          err_total;
  int          test_total;
  int          cycle_count;
  int          pulse_cnt [ADC_CH];  // highs per channel in one window
  logic [31:0] lcg_state;

  rp_analog_top dut0 (
    .adc_clk_01  (adc_clk_01),
    .rst_i       (rst_i),
    .adc_rise_i  (adc_rise),
    .adc_fall_i  (adc_fall),
    .adc_dat_o   (adc_dat),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack),
    .sys_err_o   (sys_err),
    .led_o       (led),
    .exp_p_dat_i (exp_p_in),
    .exp_n_dat_i (exp_n_in),
    .exp_p_dat_o (exp_p_dat),
    .exp_n_dat_o (exp_n_dat),
    .exp_p_dir_o (exp_p_dir),
    .exp_n_dir_o (exp_n_dir),
    .dac_pwm_o   (dac_pwm)
  );

  `include "tb_checks.svh"

  always #CLK_HALF adc_clk_01 = ~adc_clk_01;

  // run limit
  always @(posedge adc_clk_01) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // numerical recipes LCG
    return lcg_state;
  endfunction

  function automatic sys_addr_t region_addr(input logic [REGION_W-1:0] region,
                                            input logic [REGION_LSB-1:0] offs);
    return {{(32 - REGION_LSB - REGION_W){1'b0}}, region, offs};
  endfunction

  // raw bit 2k from the falling half, 2k+1 from the rising half; msb kept, rest inverted
  function automatic adc_sample_t expect_sample(input adc_half_t rise, input adc_half_t fall);
    logic [ADC_DW-1:0] raw;
    for (int k = 0; k < ADC_HALF_W; k++) begin
      raw[2*k]   = fall[k];
      raw[2*k+1] = rise[k];
    end
    return {raw[ADC_DW-1], ~raw[ADC_DW-2:0]};
  endfunction

  function automatic sys_data_t hk_port(input hk_reg_e reg_sel);
    case (reg_sel)
      HK_LED:       return sys_data_t'(led);
      HK_EXP_P_DIR: return sys_data_t'(exp_p_dir);
      HK_EXP_N_DIR: return sys_data_t'(exp_n_dir);
      HK_EXP_P_OUT: return sys_data_t'(exp_p_dat);
      HK_EXP_N_OUT: return sys_data_t'(exp_n_dat);
      default:      return '0;
    endcase
  endfunction

  // 256 consecutive cycles, highs counted per channel
  task automatic count_pulses();
    for (int ch = 0; ch < ADC_CH; ch++) pulse_cnt[ch] = 0;
    repeat (256) begin
      for (int ch = 0; ch < ADC_CH; ch++) pulse_cnt[ch] += dac_pwm[ch];
      @(posedge adc_clk_01);
      #DRV_DLY;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_total++;
    if (err_total == errs_before) $display("test %s: ok", name);
    else $display("test %s: %0d mismatches", name, err_total - errs_before);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    int errs0;
    errs0 = err_total;
    check_bit("ack after reset", sys_ack, 1'b0);
    check_bit("err after reset", sys_err, 1'b0);
    for (int ch = 0; ch < ADC_CH; ch++) check_sample("adc_dat after reset", adc_dat[ch], '0);
    check_data("led after reset", sys_data_t'(led), '0);
    check_data("exp_p_dat after reset", sys_data_t'(exp_p_dat), '0);
    check_data("exp_n_dat after reset", sys_data_t'(exp_n_dat), '0);
    check_data("exp_p_dir after reset", sys_data_t'(exp_p_dir), '0);
    check_data("exp_n_dir after reset", sys_data_t'(exp_n_dir), '0);
    for (int ch = 0; ch < ADC_CH; ch++) check_bit("dac_pwm after reset", dac_pwm[ch], 1'b0);
    count_pulses();  // no settings written
    for (int ch = 0; ch < ADC_CH; ch++) check_count("pwm highs, idle", pulse_cnt[ch], 0);
    end_test("reset state", errs0);
  endtask

  task automatic test_adc();
    int          errs0;
    logic [31:0] r;
    adc_sample_t exp_q [$];  // expected words, oldest first
    errs0 = err_total;
    for (int i = 0; i < 66; i++) begin
      if (i >= 2) begin  // 2 cycle latency
        for (int ch = 0; ch < ADC_CH; ch++) begin
          check_sample($sformatf("adc set %0d ch %0d", i - 2, ch), adc_dat[ch],
                       exp_q.pop_front());
        end
      end
      if (i < 64) begin
        for (int ch = 0; ch < ADC_CH; ch++) begin
          r = next_rand();
          adc_rise[ch] = r[30:24];
          adc_fall[ch] = r[22:16];
          exp_q.push_back(expect_sample(adc_rise[ch], adc_fall[ch]));
        end
      end
      @(posedge adc_clk_01);
      #DRV_DLY;
    end
    end_test("adc conversion", errs0);
  endtask

  task automatic test_hk();
    int          errs0;
    sys_data_t   rd;
    logic [31:0] v;
    hk_reg_e     wr_regs [5];
    errs0 = err_total;
    wr_regs[0] = HK_LED;
    wr_regs[1] = HK_EXP_P_DIR;
    wr_regs[2] = HK_EXP_N_DIR;
    wr_regs[3] = HK_EXP_P_OUT;
    wr_regs[4] = HK_EXP_N_OUT;
    read_ok("hk id read", region_addr(REGION_HK, HK_ID), rd);
    check_data("hk id value", rd, HK_ID_VALUE);
    write_ok("hk id write", region_addr(REGION_HK, HK_ID), 32'hffff_ffff);  // read only
    read_ok("hk id reread", region_addr(REGION_HK, HK_ID), rd);
    check_data("hk id after write", rd, HK_ID_VALUE);
    foreach (wr_regs[i]) begin
      v = next_rand();  // upper bits must be dropped
      write_ok(wr_regs[i].name(), region_addr(REGION_HK, wr_regs[i]), v);
      check_data({wr_regs[i].name(), " port"}, hk_port(wr_regs[i]), {24'd0, v[7:0]});
      read_ok(wr_regs[i].name(), region_addr(REGION_HK, wr_regs[i]), rd);
      check_data({wr_regs[i].name(), " readback"}, rd, {24'd0, v[7:0]});
    end
    v = next_rand();
    exp_p_in = v[7:0];
    exp_n_in = v[15:8];
    read_ok("hk p in", region_addr(REGION_HK, HK_EXP_P_IN), rd);
    check_data("hk p in value", rd, {24'd0, v[7:0]});
    read_ok("hk n in", region_addr(REGION_HK, HK_EXP_N_IN), rd);
    check_data("hk n in value", rd, {24'd0, v[15:8]});
    read_ok("hk hole", region_addr(REGION_HK, 20'h08), rd);
    check_data("hk hole value", rd, '0);
    idle_cycle();
    end_test("housekeeping registers", errs0);
  endtask

  task automatic test_unmapped();
    int        errs0;
    sys_data_t rd;
    logic      ack;
    logic      err;
    errs0 = err_total;
    for (int reg_n = 0; reg_n < 8; reg_n++) begin
      if (reg_n != REGION_HK && reg_n != REGION_PDM) begin
        bus_write(region_addr(3'(reg_n), 20'h0), next_rand(), ack, err);
        check_bit($sformatf("region %0d write ack", reg_n), ack, 1'b1);
        check_bit($sformatf("region %0d write err", reg_n), err, 1'b1);
        bus_read(region_addr(3'(reg_n), 20'h10), rd, ack, err);
        check_bit($sformatf("region %0d read ack", reg_n), ack, 1'b1);
        check_bit($sformatf("region %0d read err", reg_n), err, 1'b1);
        idle_cycle();
      end
    end
    end_test("unmapped regions", errs0);
  endtask

  task automatic test_pdm();
    int          errs0;
    sys_data_t   rd;
    logic [31:0] r;
    pdm_cfg_t    cfg [ADC_CH];
    errs0 = err_total;
    cfg[0] = 8'd0;  // both ends of the range
    cfg[1] = 8'd255;
    cfg[2] = 8'd77;
    cfg[3] = 8'd128;
    for (int ch = 0; ch < ADC_CH; ch++) begin
      r = next_rand();
      write_ok($sformatf("pdm ch %0d write", ch),
               region_addr(REGION_PDM, 20'(ch * PDM_REG_STRIDE)), {r[31:8], cfg[ch]});
    end
    for (int ch = 0; ch < ADC_CH; ch++) begin
      read_ok($sformatf("pdm ch %0d read", ch),
              region_addr(REGION_PDM, 20'(ch * PDM_REG_STRIDE)), rd);
      check_data($sformatf("pdm ch %0d readback", ch), rd, {24'd0, cfg[ch]});
    end
    idle_cycle();  // settings stable from here
    count_pulses();
    for (int ch = 0; ch < ADC_CH; ch++) begin
      check_count($sformatf("pwm ch %0d highs", ch), pulse_cnt[ch], int'(cfg[ch]));
    end
    end_test("pulse density outputs", errs0);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    adc_clk_01  = 1'b0;
    rst_i       = 1'b1;
    adc_rise    = '0;
    adc_fall    = '0;
    sys_addr    = '0;
    sys_wdata   = '0;
    sys_wen     = 1'b0;
    sys_ren     = 1'b0;
    exp_p_in    = '0;
    exp_n_in    = '0;
    check_total = 0;
    err_total   = 0;
    test_total  = 0;
    cycle_count = 0;
    lcg_state   = 32'ha228_709d;
    repeat (2) @(posedge adc_clk_01);  // reset for 2 cycles
    #DRV_DLY;
    rst_i = 1'b0;
    test_reset_state();
    test_adc();
    test_hk();
    test_unmapped();
    test_pdm();
    $display("tests: %0d, checks: %0d, errors: %0d", test_total, check_total, err_total);
    if (err_total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+testbench
hdl/rp_pkg.sv
hdl/adc_capture.sv
hdl/sys_bus_decoder.sv
hdl/housekeeping_regs.sv
hdl/pdm_regs.sv
hdl/pdm_modulator.sv
hdl/rp_analog_top.sv
testbench/tb_rp_analog_top.sv
